/* vlog.f */
+incdir+include
verilog/hl_ctrl_pkg.sv
verilog/hl_ctrl_ifs.sv
verilog/cmd_regs.sv
verilog/resp_ctrl.sv
verilog/tx_keying.sv
verilog/fan_thermal.sv
verilog/status_leds.sv
verilog/hl_control_top.sv
bench/tb_hl_control.sv

/* bench/tb_hl_control.sv */
`timescale 1ns/1ps
`include "hl_ctrl_defines.svh"

module tb_hl_control;

  localparam int CLK_PERIOD   = 4;
  localparam int RST_CYCLES   = 5;
  localparam int RQST_SPACING = 16;
  localparam logic [31:0] SEED = 32'h4145_cc6d;

  // Temperatures placed between the fan thresholds
  localparam hl_ctrl_pkg::adc_word_t T_COOL    = `TEMP_20C - 12'd64;
  localparam hl_ctrl_pkg::adc_word_t T_LOW     = `TEMP_25C + 12'd16;
  localparam hl_ctrl_pkg::adc_word_t T_MED     = `TEMP_30C + 12'd16;
  localparam hl_ctrl_pkg::adc_word_t T_FULL    = `TEMP_35C + 12'd16;
  localparam hl_ctrl_pkg::adc_word_t T_HOT     = `TEMP_40C + 12'd16;
  localparam hl_ctrl_pkg::adc_word_t T_HOLD    = `TEMP_35C + 12'd4;
  localparam hl_ctrl_pkg::adc_word_t T_COOLING = `TEMP_35C - 12'd4;
  localparam hl_ctrl_pkg::cmd_addr_t ADDR_UNUSED = 6'h15;

  typedef struct {
    logic                     do_cmd;
    hl_ctrl_pkg::cmd_addr_t   addr;
    hl_ctrl_pkg::cmd_data_t   data;
    logic                     need_resp;
    logic                     run;
    logic                     ptt;
    logic                     inhibit;
    hl_ctrl_pkg::adc_word_t   temp;
    int                       clip;
    hl_ctrl_pkg::resp_frame_t exp_frame;
    logic                     exp_tx_on;
    logic                     chk_fan;
    logic                     exp_fan;
    logic [5:0]               exp_pa;
    logic                     exp_reset;
    logic                     exp_clip_led;
  } row_t;

  logic                     clk;
  logic                     slow_adc_rst;
  hl_ctrl_pkg::cmd_addr_t   cmd_addr_i;
  hl_ctrl_pkg::cmd_data_t   cmd_data_i;
  logic                     cmd_rqst_i;
  logic                     cmd_requires_resp_i;
  logic                     cmd_ptt_i;
  logic                     resp_rqst_i;
  hl_ctrl_pkg::resp_frame_t resp_o;
  logic                     run_i;
  logic                     ethup_i;
  logic                     rxclip_i;
  logic                     rxgoodlvl_i;
  logic                     ptt_i;
  logic                     tx_hang_i;
  logic                     tx_inhibit_i;
  hl_ctrl_pkg::adc_word_t   temperature_i;
  hl_ctrl_pkg::adc_word_t   fwd_pwr_i;
  hl_ctrl_pkg::adc_word_t   rev_pwr_i;
  hl_ctrl_pkg::adc_word_t   bias_current_i;
  logic                     tx_on_o;
  logic                     pa_inttr_o;
  logic                     pa_exttr_o;
  logic                     pwr_envpa_o;
  logic                     pwr_envop_o;
  logic                     pwr_envbias_o;
  logic                     rfsw_sel_o;
  logic                     fan_pwm_o;
  logic                     led_run_o;
  logic                     led_tx_o;
  logic                     led_adc75_o;
  logic                     led_adc100_o;
  logic                     hl2_reset_o;

  row_t                   rows[$];
  logic                   table_ready = 1'b0;
  int                     n_checks = 0;
  int                     frame_errs = 0;
  int                     bit_errs = 0;
  int unsigned            seed_ret;

  // Expected-state tracking while the table is built
  hl_ctrl_pkg::slot_t     exp_slot;
  logic                   exp_alt;
  logic                   pend_valid;
  logic                   clip_seen;
  hl_ctrl_pkg::cmd_addr_t pend_addr;
  hl_ctrl_pkg::cmd_data_t pend_data;
  hl_ctrl_pkg::cmd_data_t pa_word;
  hl_ctrl_pkg::cmd_data_t rst_word;
  hl_ctrl_pkg::cmd_data_t pa_data_a;
  hl_ctrl_pkg::cmd_data_t pa_data_b;
  hl_ctrl_pkg::cmd_data_t junk_data;
  hl_ctrl_pkg::cmd_data_t rst_on;
  hl_ctrl_pkg::cmd_data_t rst_off;

  hl_control_top DUT (
    .clk                 (clk),
    .slow_adc_rst        (slow_adc_rst),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_rqst_i          (cmd_rqst_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd_ptt_i           (cmd_ptt_i),
    .resp_rqst_i         (resp_rqst_i),
    .resp_o              (resp_o),
    .run_i               (run_i),
    .ethup_i             (ethup_i),
    .rxclip_i            (rxclip_i),
    .rxgoodlvl_i         (rxgoodlvl_i),
    .ptt_i               (ptt_i),
    .tx_hang_i           (tx_hang_i),
    .tx_inhibit_i        (tx_inhibit_i),
    .temperature_i       (temperature_i),
    .fwd_pwr_i           (fwd_pwr_i),
    .rev_pwr_i           (rev_pwr_i),
    .bias_current_i      (bias_current_i),
    .tx_on_o             (tx_on_o),
    .pa_inttr_o          (pa_inttr_o),
    .pa_exttr_o          (pa_exttr_o),
    .pwr_envpa_o         (pwr_envpa_o),
    .pwr_envop_o         (pwr_envop_o),
    .pwr_envbias_o       (pwr_envbias_o),
    .rfsw_sel_o          (rfsw_sel_o),
    .fan_pwm_o           (fan_pwm_o),
    .led_run_o           (led_run_o),
    .led_tx_o            (led_tx_o),
    .led_adc75_o         (led_adc75_o),
    .led_adc100_o        (led_adc100_o),
    .hl2_reset_o         (hl2_reset_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_frame(input string name, input hl_ctrl_pkg::resp_frame_t got,
                             input hl_ctrl_pkg::resp_frame_t exp, input int row);
    n_checks++;
    if (got !== exp) begin
      frame_errs++;
      $display("mismatch %s row %0d: got 0x%h, expected 0x%h", name, row, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp, input int row);
    n_checks++;
    if (got !== exp) begin
      bit_errs++;
      $display("mismatch %s row %0d: got 0x%h, expected 0x%h", name, row, got, exp);
    end
  endtask

  // Order is inttr, exttr, envpa, envop, envbias, rfsw
  task automatic check_pa_outputs(input logic [5:0] exp, input int row);
    check_bit("pa_inttr_o", pa_inttr_o, exp[5], row);
    check_bit("pa_exttr_o", pa_exttr_o, exp[4], row);
    check_bit("pwr_envpa_o", pwr_envpa_o, exp[3], row);
    check_bit("pwr_envop_o", pwr_envop_o, exp[2], row);
    check_bit("pwr_envbias_o", pwr_envbias_o, exp[1], row);
    check_bit("rfsw_sel_o", rfsw_sel_o, exp[0], row);
  endtask

  function automatic hl_ctrl_pkg::resp_frame_t slot_frame(input hl_ctrl_pkg::slot_t s,
      input logic ptt_r, input logic clip, input hl_ctrl_pkg::adc_word_t temp);
    hl_ctrl_pkg::resp_frame_t f;
    f = '0;
    f[36:35] = s;
    f[32] = ptt_r;
    case (s)
      2'd0: begin
        f[31:25] = `SLOT0_TAG;
        f[24]    = clip;
        f[7:0]   = `VERSION_MAJOR;
      end
      2'd1: begin
        f[27:16] = temp;
        f[11:0]  = fwd_pwr_i;
      end
      2'd2: begin
        f[27:16] = rev_pwr_i;
        f[11:0]  = bias_current_i;
      end
      default: f = f;
    endcase
    return f;
  endfunction

  function automatic hl_ctrl_pkg::cmd_data_t read_word(input hl_ctrl_pkg::cmd_addr_t addr);
    if (addr == `ADDR_PA_CFG) return pa_word;
    if (addr == `ADDR_RESET_CFG) return rst_word;
    return '0;
  endfunction

  // One table row whose expected frame follows the slot and alternation rules
  task automatic add_row(input logic do_cmd, input hl_ctrl_pkg::cmd_addr_t addr,
      input hl_ctrl_pkg::cmd_data_t data, input logic need_resp, input logic run,
      input logic ptt, input logic inhibit, input hl_ctrl_pkg::adc_word_t temp,
      input int clip, input logic exp_tx, input logic chk_fan, input logic exp_fan);
    row_t r;
    logic vna;
    logic pen;
    logic trd;
    r = '{do_cmd, addr, data, need_resp, run, ptt, inhibit, temp, clip,
          '0, exp_tx, chk_fan, exp_fan, '0, 1'b0, 1'b0};
    if (do_cmd && addr == `ADDR_PA_CFG) pa_word = data;
    if (do_cmd && addr == `ADDR_RESET_CFG) rst_word = data;
    if (do_cmd && need_resp && !pend_valid) begin
      pend_valid = 1'b1;
      pend_addr  = addr;
      pend_data  = read_word(addr);
    end
    if (!exp_alt && pend_valid) begin
      r.exp_frame = {1'b1, pend_addr, exp_tx, pend_data};
      pend_valid  = 1'b0;
    end else begin
      r.exp_frame = slot_frame(exp_slot, ptt, clip >= 3, temp);
    end
    exp_slot = exp_slot + 2'd1;
    exp_alt  = ~exp_alt;
    vna = pa_word[`VNA_BIT];
    pen = pa_word[`PA_EN_BIT];
    trd = pa_word[`TR_DIS_BIT];
    r.exp_pa = {exp_tx & ~vna & (pen | ~trd), exp_tx, exp_tx & ~vna & pen,
                exp_tx, exp_tx & ~vna & pen, ~vna & pen};
    r.exp_reset = rst_word[`RESET_REQ_BIT] & ~run;
    // A clip pulse keeps its LED lit far longer than the whole run
    if (clip > 0) clip_seen = 1'b1;
    r.exp_clip_led = clip_seen;
    rows.push_back(r);
  endtask

  task automatic build_table();
    exp_slot   = '0;
    exp_alt    = 1'b0;
    pend_valid = 1'b0;
    clip_seen  = 1'b0;
    pa_word    = '0;
    rst_word   = '0;
    // cmd, addr, data, resp, run, ptt, inhibit, temp, clip, tx_on, chk_fan, fan
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, `ADDR_PA_CFG, pa_data_a, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b0, T_COOL, 0, 1'b1, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b1, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    // Command responses land on even requests only
    add_row(1'b1, `ADDR_PA_CFG, pa_data_b, 1'b1, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, ADDR_UNUSED, junk_data, 1'b1, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 1, 1'b0, 1'b1, 1'b0);
    // Heat up in steps with ptt held
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b0, T_LOW, 0, 1'b1, 1'b0, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b0, T_MED, 0, 1'b1, 1'b0, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b0, T_FULL, 0, 1'b1, 1'b1, 1'b1);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b0, T_HOT, 3, 1'b0, 1'b1, 1'b1);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b0, T_HOLD, 0, 1'b0, 1'b1, 1'b1);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b1, 1'b0, T_COOLING, 0, 1'b1, 1'b1, 1'b1);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    // Reboot request only takes effect with run low
    add_row(1'b1, `ADDR_RESET_CFG, rst_on, 1'b0, 1'b1, 1'b1, 1'b0, T_COOL, 0, 1'b1, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b0, 1'b1, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b1, `ADDR_RESET_CFG, rst_off, 1'b0, 1'b0, 1'b1, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
    add_row(1'b0, 6'h00, '0, 1'b0, 1'b1, 1'b0, 1'b0, T_COOL, 0, 1'b0, 1'b1, 1'b0);
  endtask

  task automatic apply_row(input row_t r, input int idx);
    @(negedge clk);
    run_i         = r.run;
    ptt_i         = r.ptt;
    tx_inhibit_i  = r.inhibit;
    temperature_i = r.temp;
    if (r.do_cmd) begin
      cmd_addr_i          = r.addr;
      cmd_data_i          = r.data;
      cmd_requires_resp_i = r.need_resp;
      cmd_rqst_i          = 1'b1;
      @(negedge clk);
      cmd_rqst_i          = 1'b0;
      cmd_requires_resp_i = 1'b0;
    end
    if (r.clip > 0) begin
      rxclip_i = 1'b1;
      repeat (r.clip) @(negedge clk);
      rxclip_i = 1'b0;
    end
    repeat (RQST_SPACING) @(negedge clk);
    resp_rqst_i = 1'b1;
    @(negedge clk);
    resp_rqst_i = 1'b0;
    check_frame("resp_o", resp_o, r.exp_frame, idx);
    check_bit("tx_on_o", tx_on_o, r.exp_tx_on, idx);
    check_pa_outputs(r.exp_pa, idx);
    if (r.chk_fan) check_bit("fan_pwm_o", fan_pwm_o, r.exp_fan, idx);
    check_bit("hl2_reset_o", hl2_reset_o, r.exp_reset, idx);
    // Ethernet stays down and the run LED is dark when not running
    check_bit("led_run_o", led_run_o, ~r.run, idx);
    check_bit("led_tx_o", led_tx_o, r.run ? ~r.exp_tx_on : 1'b1, idx);
    check_bit("led_adc100_o", led_adc100_o, r.run ? ~r.exp_clip_led : 1'b1, idx);
    check_bit("led_adc75_o", led_adc75_o, 1'b1, idx);
  endtask

  initial begin
    wait (table_ready);
    #(rows.size() * 40 * CLK_PERIOD);
    $display("Timeout: the test table did not finish in time, %0d checks done", n_checks);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    seed_ret            = $urandom(SEED);
    clk                 = 1'b0;
    slow_adc_rst        = 1'b1;
    cmd_addr_i          = '0;
    cmd_data_i          = '0;
    cmd_rqst_i          = 1'b0;
    cmd_requires_resp_i = 1'b0;
    cmd_ptt_i           = 1'b0;
    resp_rqst_i         = 1'b0;
    run_i               = 1'b1;
    ethup_i             = 1'b0;
    rxclip_i            = 1'b0;
    rxgoodlvl_i         = 1'b0;
    ptt_i               = 1'b0;
    tx_hang_i           = 1'b0;
    tx_inhibit_i        = 1'b0;
    temperature_i       = T_COOL;
    fwd_pwr_i           = 12'($urandom());
    rev_pwr_i           = 12'($urandom());
    bias_current_i      = 12'($urandom());
    // First word keeps the PA path in and the second one selects vna
    pa_data_a = ($urandom() & ~(32'h1 << `VNA_BIT)) | (32'h1 << `PA_EN_BIT);
    pa_data_b = $urandom() | (32'h1 << `VNA_BIT);
    junk_data = $urandom();
    rst_on    = $urandom() | (32'h1 << `RESET_REQ_BIT);
    rst_off   = $urandom() & ~(32'h1 << `RESET_REQ_BIT);
    build_table();
    table_ready = 1'b1;

    repeat (RST_CYCLES) @(negedge clk);
    slow_adc_rst = 1'b0;
    check_frame("resp_o", resp_o, '0, 0);
    check_bit("tx_on_o", tx_on_o, 1'b0, 0);
    check_pa_outputs(6'b000000, 0);
    check_bit("fan_pwm_o", fan_pwm_o, 1'b0, 0);
    check_bit("hl2_reset_o", hl2_reset_o, 1'b0, 0);

    foreach (rows[i]) begin
      apply_row(rows[i], i + 1);
    end

    // One cycle of good level lights its LED while running
    @(negedge clk);
    rxgoodlvl_i = 1'b1;
    @(negedge clk);
    rxgoodlvl_i = 1'b0;
    @(negedge clk);
    check_bit("led_adc75_o", led_adc75_o, 1'b0, rows.size() + 1);
    // Both level LEDs go dark with run low
    run_i = 1'b0;
    @(negedge clk);
    check_bit("led_adc75_o", led_adc75_o, 1'b1, rows.size() + 1);
    check_bit("led_adc100_o", led_adc100_o, 1'b1, rows.size() + 1);

    $display("Checks: %0d, frame errors: %0d, bit errors: %0d", n_checks, frame_errs, bit_errs);
    if (frame_errs + bit_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* verilog/hl_control_top.sv */
`timescale 1ns/1ps

module hl_control_top (
  input  logic                     clk,
  input  logic                     slow_adc_rst,
  input  hl_ctrl_pkg::cmd_addr_t   cmd_addr_i,
  input  hl_ctrl_pkg::cmd_data_t   cmd_data_i,
  input  logic                     cmd_rqst_i,
  input  logic                     cmd_requires_resp_i,
  input  logic                     cmd_ptt_i,
  input  logic                     resp_rqst_i,
  output hl_ctrl_pkg::resp_frame_t resp_o,
  input  logic                     run_i,
  input  logic                     ethup_i,
  input  logic                     rxclip_i,
  input  logic                     rxgoodlvl_i,
  input  logic                     ptt_i,
  input  logic                     tx_hang_i,
  input  logic                     tx_inhibit_i,
  input  hl_ctrl_pkg::adc_word_t   temperature_i,
  input  hl_ctrl_pkg::adc_word_t   fwd_pwr_i,
  input  hl_ctrl_pkg::adc_word_t   rev_pwr_i,
  input  hl_ctrl_pkg::adc_word_t   bias_current_i,
  output logic                     tx_on_o,
  output logic                     pa_inttr_o,
  output logic                     pa_exttr_o,
  output logic                     pwr_envpa_o,
  output logic                     pwr_envop_o,
  output logic                     pwr_envbias_o,
  output logic                     rfsw_sel_o,
  output logic                     fan_pwm_o,
  output logic                     led_run_o,
  output logic                     led_tx_o,
  output logic                     led_adc75_o,
  output logic                     led_adc100_o,
  output logic                     hl2_reset_o
);

  logic vna;
  logic pa_enable;
  logic tr_disable;
  logic int_ptt;
  logic hl2_reset_req;
  logic temp_enable;
  logic ptt_resp;

  cmd_bus_if cmd_bus ();
  reg_rd_if  reg_rd ();

  assign cmd_bus.addr          = cmd_addr_i;
  assign cmd_bus.data          = cmd_data_i;
  assign cmd_bus.rqst          = cmd_rqst_i;
  assign cmd_bus.requires_resp = cmd_requires_resp_i;

  // Reboot from config flash only while the host is not running
  assign hl2_reset_o = hl2_reset_req & ~run_i;

  cmd_regs u_cmd_regs (
    .clk             (clk),
    .slow_adc_rst    (slow_adc_rst),
    .cmd             (cmd_bus.sink),
    .rd              (reg_rd.slave),
    .cmd_ptt_i       (cmd_ptt_i),
    .vna_o           (vna),
    .pa_enable_o     (pa_enable),
    .tr_disable_o    (tr_disable),
    .int_ptt_o       (int_ptt),
    .hl2_reset_req_o (hl2_reset_req)
  );

  resp_ctrl u_resp_ctrl (
    .clk            (clk),
    .slow_adc_rst   (slow_adc_rst),
    .cmd            (cmd_bus.sink),
    .rd             (reg_rd.master),
    .resp_rqst_i    (resp_rqst_i),
    .rxclip_i       (rxclip_i),
    .tx_on_i        (tx_on_o),
    .ptt_resp_i     (ptt_resp),
    .temperature_i  (temperature_i),
    .fwd_pwr_i      (fwd_pwr_i),
    .rev_pwr_i      (rev_pwr_i),
    .bias_current_i (bias_current_i),
    .resp_o         (resp_o)
  );

  tx_keying u_tx_keying (
    .clk           (clk),
    .slow_adc_rst  (slow_adc_rst),
    .int_ptt_i     (int_ptt),
    .ptt_i         (ptt_i),
    .tx_hang_i     (tx_hang_i),
    .tx_inhibit_i  (tx_inhibit_i),
    .run_i         (run_i),
    .temp_enable_i (temp_enable),
    .vna_i         (vna),
    .pa_enable_i   (pa_enable),
    .tr_disable_i  (tr_disable),
    .tx_on_o       (tx_on_o),
    .ptt_resp_o    (ptt_resp),
    .pa_inttr_o    (pa_inttr_o),
    .pa_exttr_o    (pa_exttr_o),
    .pwr_envpa_o   (pwr_envpa_o),
    .pwr_envop_o   (pwr_envop_o),
    .pwr_envbias_o (pwr_envbias_o),
    .rfsw_sel_o    (rfsw_sel_o)
  );

  fan_thermal u_fan_thermal (
    .clk           (clk),
    .slow_adc_rst  (slow_adc_rst),
    .temperature_i (temperature_i),
    .fan_pwm_o     (fan_pwm_o),
    .temp_enable_o (temp_enable)
  );

  status_leds u_status_leds (
    .clk          (clk),
    .slow_adc_rst (slow_adc_rst),
    .run_i        (run_i),
    .tx_on_i      (tx_on_o),
    .ethup_i      (ethup_i),
    .rxclip_i     (rxclip_i),
    .rxgoodlvl_i  (rxgoodlvl_i),
    .led_run_o    (led_run_o),
    .led_tx_o     (led_tx_o),
    .led_adc75_o  (led_adc75_o),
    .led_adc100_o (led_adc100_o)
  );

endmodule

/* verilog/status_leds.sv */
`timescale 1ns/1ps
`include "hl_ctrl_defines.svh"

module status_leds (
  input  logic clk,
  input  logic slow_adc_rst,
  input  logic run_i,
  input  logic tx_on_i,
  input  logic ethup_i,
  input  logic rxclip_i,
  input  logic rxgoodlvl_i,
  output logic led_run_o,
  output logic led_tx_o,
  output logic led_adc75_o,
  output logic led_adc100_o
);

  localparam int MS_W = $clog2(`MS_TICKS);

  logic [MS_W-1:0] ms_cnt;
  logic            ms_tick;
  logic [8:0]      blink_cnt;
  logic            win_tick;
  logic [1:0]      stretch_in;
  logic [1:0]      stretch_on;

  assign ms_tick  = (ms_cnt == MS_W'(`MS_TICKS - 1));
  // One pulse every 64 ms
  assign win_tick = ms_tick & (&blink_cnt[5:0]);

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      ms_cnt    <= '0;
      blink_cnt <= '0;
    end else if (ms_tick) begin
      ms_cnt    <= '0;
      blink_cnt <= blink_cnt + 9'd1;
    end else begin
      ms_cnt <= ms_cnt + 1'b1;
    end
  end

  // Bit 0 is the good level LED, bit 1 the clip LED
  assign stretch_in = {rxclip_i, rxgoodlvl_i};

  for (genvar i = 0; i < 2; i++) begin : g_stretch
    logic [1:0] phase;

    // Phase 0 is dark, then lit until three window ticks pass
    always_ff @(posedge clk) begin
      if (slow_adc_rst) begin
        phase <= 2'd0;
      end else if (phase == 2'd0) begin
        if (stretch_in[i]) phase <= 2'd1;
      end else if (win_tick) begin
        phase <= phase + 2'd1;
      end
    end

    assign stretch_on[i] = (phase != 2'd0);
  end

  // LEDs are active low
  assign led_run_o    = run_i ? 1'b0 : ~(ethup_i & blink_cnt[8]);
  assign led_tx_o     = run_i ? ~tx_on_i : 1'b1;
  assign led_adc75_o  = run_i ? ~stretch_on[0] : 1'b1;
  assign led_adc100_o = run_i ? ~stretch_on[1] : 1'b1;

endmodule

/* verilog/fan_thermal.sv */
`timescale 1ns/1ps
`include "hl_ctrl_defines.svh"

module fan_thermal (
  input  logic                   clk,
  input  logic                   slow_adc_rst,
  input  hl_ctrl_pkg::adc_word_t temperature_i,
  output logic                   fan_pwm_o,
  output logic                   temp_enable_o
);

  hl_ctrl_pkg::fan_state_t state;
  hl_ctrl_pkg::fan_state_t state_next;
  logic [`FAN_CNT_W-1:0]   fan_cnt;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      state   <= hl_ctrl_pkg::FAN_OFF;
      fan_cnt <= '0;
    end else begin
      state   <= state_next;
      fan_cnt <= fan_cnt + 1'b1;
    end
  end

  // Each step up and down is 5 degrees apart for hysteresis
  always_comb begin
    state_next    = state;
    fan_pwm_o     = 1'b0;
    temp_enable_o = 1'b1;
    case (state)
      hl_ctrl_pkg::FAN_OFF: begin
        if (temperature_i > `TEMP_25C) state_next = hl_ctrl_pkg::FAN_LOW;
      end
      hl_ctrl_pkg::FAN_LOW: begin
        if (temperature_i > `TEMP_30C) state_next = hl_ctrl_pkg::FAN_MED;
        else if (temperature_i < `TEMP_20C) state_next = hl_ctrl_pkg::FAN_OFF;
        // 50% duty
        fan_pwm_o = fan_cnt[`FAN_CNT_W-1];
      end
      hl_ctrl_pkg::FAN_MED: begin
        if (temperature_i > `TEMP_35C) state_next = hl_ctrl_pkg::FAN_FULL;
        else if (temperature_i < `TEMP_25C) state_next = hl_ctrl_pkg::FAN_LOW;
        // 75% duty
        fan_pwm_o = fan_cnt[`FAN_CNT_W-1] | fan_cnt[`FAN_CNT_W-2];
      end
      hl_ctrl_pkg::FAN_FULL: begin
        if (temperature_i > `TEMP_40C) state_next = hl_ctrl_pkg::FAN_OVERHEAT;
        else if (temperature_i < `TEMP_30C) state_next = hl_ctrl_pkg::FAN_MED;
        fan_pwm_o = 1'b1;
      end
      hl_ctrl_pkg::FAN_OVERHEAT: begin
        if (temperature_i < `TEMP_35C) state_next = hl_ctrl_pkg::FAN_FULL;
        fan_pwm_o     = 1'b1;
        temp_enable_o = 1'b0;
      end
      default: state_next = hl_ctrl_pkg::FAN_OFF;
    endcase
  end

  // Fan runs full through overheat and on the step back down
  a_overheat_fan: assert property (@(posedge clk) disable iff (slow_adc_rst)
    (state == hl_ctrl_pkg::FAN_OVERHEAT) |-> fan_pwm_o ##1 fan_pwm_o);

endmodule

/* verilog/tx_keying.sv */
`timescale 1ns/1ps

module tx_keying (
  input  logic clk,
  input  logic slow_adc_rst,
  input  logic int_ptt_i,
  input  logic ptt_i,
  input  logic tx_hang_i,
  input  logic tx_inhibit_i,
  input  logic run_i,
  input  logic temp_enable_i,
  input  logic vna_i,
  input  logic pa_enable_i,
  input  logic tr_disable_i,
  output logic tx_on_o,
  output logic ptt_resp_o,
  output logic pa_inttr_o,
  output logic pa_exttr_o,
  output logic pwr_envpa_o,
  output logic pwr_envop_o,
  output logic pwr_envbias_o,
  output logic rfsw_sel_o
);

  logic ptt_resp;
  logic pa_path;

  assign tx_on_o = (int_ptt_i | ptt_i | tx_hang_i) & ~tx_inhibit_i & run_i & temp_enable_i;

  // External PA is in circuit unless in vna mode
  assign pa_path = ~vna_i & pa_enable_i;

  assign pwr_envop_o   = tx_on_o;
  assign pa_exttr_o    = tx_on_o;
  assign pwr_envpa_o   = tx_on_o & pa_path;
  assign pwr_envbias_o = tx_on_o & pa_path;
  assign pa_inttr_o    = tx_on_o & ~vna_i & (pa_enable_i | ~tr_disable_i);
  assign rfsw_sel_o    = pa_path;

  // Hang time is not reported back to the host
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      ptt_resp <= 1'b0;
    end else begin
      ptt_resp <= ptt_i;
    end
  end

  assign ptt_resp_o = ptt_resp;

endmodule

/* verilog/resp_ctrl.sv */
`timescale 1ns/1ps
`include "hl_ctrl_defines.svh"

module resp_ctrl (
  input  logic                     clk,
  input  logic                     slow_adc_rst,
  cmd_bus_if.sink                  cmd,
  reg_rd_if.master                 rd,
  input  logic                     resp_rqst_i,
  input  logic                     rxclip_i,
  input  logic                     tx_on_i,
  input  logic                     ptt_resp_i,
  input  hl_ctrl_pkg::adc_word_t   temperature_i,
  input  hl_ctrl_pkg::adc_word_t   fwd_pwr_i,
  input  hl_ctrl_pkg::adc_word_t   rev_pwr_i,
  input  hl_ctrl_pkg::adc_word_t   bias_current_i,
  output hl_ctrl_pkg::resp_frame_t resp_o
);

  hl_ctrl_pkg::resp_state_t state;
  hl_ctrl_pkg::cmd_addr_t   rsp_addr;
  hl_ctrl_pkg::cmd_data_t   rsp_data;
  hl_ctrl_pkg::slot_t       slot;
  hl_ctrl_pkg::resp_frame_t frame;
  hl_ctrl_pkg::cmd_data_t   slot_payload;
  logic                     rd_req;
  logic                     alt;
  logic [1:0]               clip_cnt;
  logic                     new_cmd;
  logic                     commit;

  assign new_cmd = cmd.rqst & cmd.requires_resp;
  // Command responses only go out on every other request
  assign commit  = resp_rqst_i & ~alt & (state == hl_ctrl_pkg::RESP_WAIT);

  assign rd.req  = rd_req;
  assign rd.addr = rsp_addr;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      state  <= hl_ctrl_pkg::RESP_IDLE;
      rd_req <= 1'b0;
    end else begin
      case (state)
        hl_ctrl_pkg::RESP_IDLE: begin
          if (new_cmd) state <= hl_ctrl_pkg::RESP_READ;
        end
        hl_ctrl_pkg::RESP_READ: begin
          // Previous handshake must be fully closed before a new req
          if (!rd.ack) begin
            rd_req <= 1'b1;
          end else if (rd_req) begin
            rd_req <= 1'b0;
            state  <= hl_ctrl_pkg::RESP_WAIT;
          end
        end
        hl_ctrl_pkg::RESP_WAIT: begin
          if (commit) begin
            state <= new_cmd ? hl_ctrl_pkg::RESP_READ : hl_ctrl_pkg::RESP_IDLE;
          end
        end
        default: state <= hl_ctrl_pkg::RESP_IDLE;
      endcase
    end
  end

  // Pending response, queue depth one
  always_ff @(posedge clk) begin
    if (new_cmd && (state == hl_ctrl_pkg::RESP_IDLE || commit)) begin
      rsp_addr <= cmd.addr;
    end
    if (state == hl_ctrl_pkg::RESP_READ && rd.ack && rd_req) begin
      rsp_data <= rd.data;
    end
  end

  always_comb begin
    case (slot)
      // Bits 15:8 held the dsiq status, now zero
      2'd0:    slot_payload = {`SLOT0_TAG, &clip_cnt, 16'h0000, `VERSION_MAJOR};
      2'd1:    slot_payload = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      2'd2:    slot_payload = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default: slot_payload = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      frame    <= '0;
      slot     <= '0;
      alt      <= 1'b0;
      clip_cnt <= 2'd0;
    end else if (resp_rqst_i) begin
      alt      <= ~alt;
      clip_cnt <= 2'd0;
      // Slot still advances when a command response replaces it
      slot     <= slot + 2'd1;
      if (commit) begin
        frame <= {1'b1, rsp_addr, tx_on_i, rsp_data};
      end else begin
        frame <= {3'b000, slot, 2'b00, ptt_resp_i, slot_payload};
      end
    end else if (clip_cnt != 2'd3) begin
      clip_cnt <= clip_cnt + {1'b0, rxclip_i};
    end
  end

  assign resp_o = frame;

  // Request stays up until the register block answers
  a_req_held: assert property (@(posedge clk) disable iff (slow_adc_rst)
    rd_req && !rd.ack |=> rd_req);

endmodule

/* verilog/cmd_regs.sv */
`timescale 1ns/1ps
`include "hl_ctrl_defines.svh"

module cmd_regs (
  input  logic    clk,
  input  logic    slow_adc_rst,
  cmd_bus_if.sink cmd,
  reg_rd_if.slave rd,
  input  logic    cmd_ptt_i,
  output logic    vna_o,
  output logic    pa_enable_o,
  output logic    tr_disable_o,
  output logic    int_ptt_o,
  output logic    hl2_reset_req_o
);

  hl_ctrl_pkg::cmd_data_t pa_cfg;
  hl_ctrl_pkg::cmd_data_t reset_cfg;
  hl_ctrl_pkg::cmd_data_t rd_word;
  hl_ctrl_pkg::cmd_data_t rd_data;
  logic                   int_ptt;
  logic                   ack;

  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      pa_cfg    <= '0;
      reset_cfg <= '0;
      int_ptt   <= 1'b0;
    end else if (cmd.rqst) begin
      // PTT rides along with every command
      int_ptt <= cmd_ptt_i;
      if (cmd.addr == `ADDR_PA_CFG) begin
        pa_cfg <= cmd.data;
      end else if (cmd.addr == `ADDR_RESET_CFG) begin
        reset_cfg <= cmd.data;
      end
    end
  end

  always_comb begin
    case (rd.addr)
      `ADDR_PA_CFG:    rd_word = pa_cfg;
      `ADDR_RESET_CFG: rd_word = reset_cfg;
      default:         rd_word = '0;
    endcase
  end

  // Answer one cycle after req, release one cycle after req drops
  always_ff @(posedge clk) begin
    if (slow_adc_rst) begin
      ack <= 1'b0;
    end else if (rd.req && !ack) begin
      ack <= 1'b1;
    end else if (!rd.req && ack) begin
      ack <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.req && !ack) begin
      rd_data <= rd_word;
    end
  end

  assign rd.ack  = ack;
  assign rd.data = rd_data;

  assign vna_o           = pa_cfg[`VNA_BIT];
  assign pa_enable_o     = pa_cfg[`PA_EN_BIT];
  assign tr_disable_o    = pa_cfg[`TR_DIS_BIT];
  assign hl2_reset_req_o = reset_cfg[`RESET_REQ_BIT];
  assign int_ptt_o       = int_ptt;

  // An ack only ever answers a pending request
  a_ack_after_req: assert property (@(posedge clk) disable iff (slow_adc_rst)
    $rose(rd.ack) |-> $past(rd.req));

endmodule

/* verilog/hl_ctrl_ifs.sv */
`timescale 1ns/1ps

// Host command bus, a command is valid whenever rqst is high
interface cmd_bus_if;
  hl_ctrl_pkg::cmd_addr_t addr;
  hl_ctrl_pkg::cmd_data_t data;
  logic                   rqst;
  logic                   requires_resp;

  modport src (
    output addr,
    output data,
    output rqst,
    output requires_resp
  );

  modport sink (
    input addr,
    input data,
    input rqst,
    input requires_resp
  );
endinterface

// Register read-back, four-phase req/ack
interface reg_rd_if;
  logic                   req;
  hl_ctrl_pkg::cmd_addr_t addr;
  logic                   ack;
  hl_ctrl_pkg::cmd_data_t data;

  modport master (output req, output addr, input ack, input data);
  modport slave (input req, input addr, output ack, output data);
endinterface

/* verilog/hl_ctrl_pkg.sv */
package hl_ctrl_pkg;

  typedef logic [5:0]  cmd_addr_t;
  typedef logic [31:0] cmd_data_t;
  typedef logic [11:0] adc_word_t;
  typedef logic [1:0]  slot_t;
  typedef logic [39:0] resp_frame_t;

  // Command response sequencing
  typedef enum logic [1:0] {
    RESP_IDLE,
    RESP_READ,
    RESP_WAIT
  } resp_state_t;

  // Fan speed steps
  typedef enum logic [2:0] {
    FAN_OFF,
    FAN_LOW,
    FAN_MED,
    FAN_FULL,
    FAN_OVERHEAT
  } fan_state_t;

endpackage

/* include/hl_ctrl_defines.svh */
`ifndef HL_CTRL_DEFINES_SVH
`define HL_CTRL_DEFINES_SVH

// Command register addresses
`define ADDR_PA_CFG     6'h09
`define ADDR_RESET_CFG  6'h3a

// Fields of the PA configuration word
`define VNA_BIT         23
`define PA_EN_BIT       19
`define TR_DIS_BIT      18

// Reboot request in the reset word
`define RESET_REQ_BIT   0

`define VERSION_MAJOR   8'd73

// Sensor code = ((T * 0.01 + 0.5) / 3.26) * 4096
`define TEMP_20C        12'b001101101111
`define TEMP_25C        12'b001110101110
`define TEMP_30C        12'b001111101101
`define TEMP_35C        12'b010000101011
`define TEMP_40C        12'b010001101011

// Clocks per millisecond at 2.5 MHz
`define MS_TICKS        2500
`define FAN_CNT_W       16

// Fixed tag carried in slot 0
`define SLOT0_TAG       7'b0001111

`endif
